//--- Makefile
# Verilator build and run for the mini game testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mini_game
FILELIST  := mini_game.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/mini_game_settings.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/mini_game_assert.sv
// ********************
// mini game assertions
// bound to the game FSM, checks the done pulse,
// the score range and the led-off level
// ********************

`timescale 1ns/1ps
`default_nettype none

module mini_game_assert #(
    parameter int unsigned WIN_COUNT = 3
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire mini_game_pkg::game_state_t state,
    input  wire mini_game_pkg::score_t      count,
    input  wire                             game_done,
    input  wire                             game_led_off
);
    import mini_game_pkg::*;

    // done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clk) disable iff (reset) game_done |=> !game_done
    ) else $error("game_done stayed high for more than one cycle");

    // score never passes the win count
    count_in_range: assert property (
        @(posedge clk) disable iff (reset) count <= score_t'(WIN_COUNT)
    ) else $error("count went above the win count");

    // target hidden outside the on window
    led_off_outside_on: assert property (
        @(posedge clk) disable iff (reset) (state != led_on) |-> game_led_off
    ) else $error("game_led_off low while the FSM is not in led_on");

endmodule

bind game_fsm mini_game_assert #(
    .WIN_COUNT (WIN_COUNT)
) u_fsm_assert (
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .count        (count),
    .game_done    (game_done),
    .game_led_off (game_led_off)
);

`default_nettype wire

//--- dv/mini_game_checker.sv
// ********************
// mini game checker
// cycle model of the game built from the port
// timing, judges each round and counts mismatches
// ********************

`timescale 1ns/1ps
`default_nettype none

module mini_game_checker #(
    parameter int unsigned ON_CYCLES  = 16,
    parameter int unsigned OFF_CYCLES = 8,
    parameter int unsigned WIN_COUNT  = 3
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              enable_game,
    input  wire mini_game_pkg::switch_word_t spdt_switches,
    input  wire mini_game_pkg::led_index_t   random_out,
    input  wire mini_game_pkg::led_index_t   random_led,
    input  wire mini_game_pkg::score_t       count,
    input  wire                              game_done,
    input  wire                              game_led_off,
    output int                               err_count,
    output int                               round_count,
    output int                               win_total
);
    import mini_game_pkg::*;

    game_state_t  exp_state;
    logic         exp_latch;
    int           exp_count;
    logic         exp_done;
    logic         exp_led_off;
    led_index_t   exp_target;
    int           phase_cnt;
    switch_word_t prev_sw;
    switch_word_t presses[$];

    // round is correct only if every press is the lone target switch
    function automatic bit judge_round(input switch_word_t words[$], input led_index_t target);
        bit           ok;
        switch_word_t want;
        want = switch_word_t'(1) << target;
        ok   = (words.size() != 0);
        foreach (words[i]) begin
            if (words[i] != want) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_state   <= idle;
            exp_latch   <= 1'b0;
            exp_count   <= 0;
            exp_done    <= 1'b0;
            exp_led_off <= 1'b1;
            exp_target  <= '0;
            phase_cnt   <= 0;
            prev_sw     <= '0;
            round_count <= 0;
            win_total   <= 0;
            presses.delete();
        end else begin
            prev_sw  <= spdt_switches;
            exp_done <= 1'b0;
            if (enable_game && !exp_done) begin
                exp_latch <= 1'b1;
            end
            case (exp_state)
                idle: begin
                    if (exp_latch && !exp_done) begin
                        // new game with its first target
                        presses.delete();
                        exp_target  <= random_out;
                        exp_led_off <= 1'b0;
                        exp_count   <= 0;
                        phase_cnt   <= 0;
                        exp_state   <= led_on;
                    end
                end
                led_on: begin
                    if (spdt_switches != '0 && spdt_switches != prev_sw) begin
                        presses.push_back(spdt_switches);
                    end
                    if (phase_cnt == int'(ON_CYCLES)) begin
                        round_count <= round_count + 1;
                        exp_led_off <= 1'b1;
                        phase_cnt   <= 0;
                        exp_state   <= led_off;
                        if (!judge_round(presses, exp_target)) begin
                            exp_count <= 0;
                        end else if (exp_count + 1 == int'(WIN_COUNT)) begin
                            // win ends the game
                            exp_count <= 0;
                            exp_done  <= 1'b1;
                            exp_latch <= 1'b0;
                            exp_state <= idle;
                            win_total <= win_total + 1;
                        end else begin
                            exp_count <= exp_count + 1;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1;
                    end
                end
                led_off: begin
                    if (phase_cnt == int'(OFF_CYCLES)) begin
                        presses.delete();
                        exp_target  <= random_out;
                        exp_led_off <= 1'b0;
                        phase_cnt   <= 0;
                        exp_state   <= led_on;
                    end else begin
                        phase_cnt <= phase_cnt + 1;
                    end
                end
                default: exp_state <= idle;
            endcase
        end
    end

    task automatic report_mismatch(input string name, input int exp_v, input int got_v);
        $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp_v, got_v);
        err_count = err_count + 1;
    endtask

    initial err_count = 0;

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (game_led_off !== exp_led_off) begin
                report_mismatch("game_led_off", int'(exp_led_off), int'(game_led_off));
            end
            if (game_done !== exp_done) begin
                report_mismatch("game_done", int'(exp_done), int'(game_done));
            end
            if (count !== score_t'(exp_count)) begin
                report_mismatch("count", exp_count, int'(count));
            end
            // target holds its value outside the on window
            if (random_led !== exp_target) begin
                report_mismatch("random_led", int'(exp_target), int'(random_led));
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mini_game.sv
// ********************
// mini game testbench
// clock, reset, random rounds of switch presses,
// timeout and final report
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mini_game_settings.svh"

module tb_mini_game;
    import mini_game_pkg::*;

    // 8 cycles per second gives 16 on and 8 off
    localparam int unsigned CLOCK_FREQ = 8;
    localparam int unsigned WIN_COUNT  = 3;
    localparam int unsigned ON_CYCLES  = CLOCK_FREQ * 2;
    localparam int unsigned OFF_CYCLES = CLOCK_FREQ * 1;
    localparam int NUM_ROUNDS      = 60;
    localparam int DIRECTED_ROUNDS = 6;
    localparam int ROUND_CYCLES    = ON_CYCLES + OFF_CYCLES + 2;
    localparam int TIMEOUT_CYCLES  = 80 * ROUND_CYCLES + 420;

    // round kinds
    localparam int K_SILENT    = 0;
    localparam int K_CORRECT   = 1;
    localparam int K_WRONG     = 2;
    localparam int K_MULTI     = 3;
    localparam int K_GOOD_BAD  = 4;
    localparam int K_BAD_GOOD  = 5;
    localparam int K_HIGH_ONLY = 6;

    logic         clk = 1'b0;
    logic         reset;
    logic         enable_game;
    switch_word_t spdt_switches;
    led_index_t   random_out;
    led_index_t   random_led;
    score_t       count;
    logic         game_done;
    logic         game_led_off;
    int           err_count;
    int           round_count;
    int           win_total;
    int           other_errors;
    int           cycle_count;

    always #10 clk = ~clk;

    mini_game #(
        .CLOCK_FREQ   (CLOCK_FREQ),
        .ON_TIME_SEC  (2),
        .OFF_TIME_SEC (1),
        .WIN_COUNT    (WIN_COUNT)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .enable_game   (enable_game),
        .spdt_switches (spdt_switches),
        .random_out    (random_out),
        .random_led    (random_led),
        .count         (count),
        .game_done     (game_done),
        .game_led_off  (game_led_off)
    );

    mini_game_checker #(
        .ON_CYCLES  (ON_CYCLES),
        .OFF_CYCLES (OFF_CYCLES),
        .WIN_COUNT  (WIN_COUNT)
    ) u_checker (
        .clk           (clk),
        .reset         (reset),
        .enable_game   (enable_game),
        .spdt_switches (spdt_switches),
        .random_out    (random_out),
        .random_led    (random_led),
        .count         (count),
        .game_done     (game_done),
        .game_led_off  (game_led_off),
        .err_count     (err_count),
        .round_count   (round_count),
        .win_total     (win_total)
    );

    // fresh target candidate every cycle
    always @(posedge clk) begin
        random_out <= led_index_t'($urandom % `MG_NUM_TARGETS);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: game rounds did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // any target index other than the given one
    function automatic led_index_t other_index(input led_index_t target);
        return led_index_t'((target + 1 + $urandom % (`MG_NUM_TARGETS - 1)) % `MG_NUM_TARGETS);
    endfunction

    // press held 3 cycles then released for 2
    task automatic tap(input switch_word_t word);
        spdt_switches <= word;
        repeat (3) @(posedge clk);
        spdt_switches <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic play_round(input int kind, input led_index_t target);
        switch_word_t good;
        switch_word_t bad;
        good = switch_word_t'(1) << target;
        bad  = switch_word_t'(1) << other_index(target);
        @(posedge clk);
        case (kind)
            K_SILENT:   ;
            K_CORRECT:  tap(good);
            K_WRONG:    tap(bad);
            K_MULTI:    tap(good | bad);
            K_GOOD_BAD: begin
                tap(good);
                tap(bad);
            end
            K_BAD_GOOD: begin
                tap(bad);
                tap(good);
            end
            // switches 10 to 14 are never targets
            K_HIGH_ONLY: tap(switch_word_t'(1) << (10 + $urandom % 5));
        endcase
        while (game_led_off !== 1'b1) @(negedge clk);
    endtask

    initial begin
        int         r;
        int         kind;
        led_index_t target;
        void'($urandom(77));
        reset         = 1'b1;
        enable_game   = 1'b0;
        spdt_switches = '0;
        random_out    = '0;
        cycle_count   = 0;
        other_errors  = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);
        enable_game <= 1'b1;
        for (r = 0; r < NUM_ROUNDS; r++) begin
            // directed correct rounds force two wins first
            kind = (r < DIRECTED_ROUNDS) ? K_CORRECT : int'($urandom % 7);
            while (game_led_off !== 1'b0) @(negedge clk);
            target = random_led;
            play_round(kind, target);
        end
        repeat (OFF_CYCLES + 4) @(posedge clk);
        if (round_count != NUM_ROUNDS) begin
            $display("checker saw %0d rounds, %0d were played", round_count, NUM_ROUNDS);
            other_errors++;
        end
        if (win_total < 2) begin
            $display("the directed correct rounds did not produce two wins");
            other_errors++;
        end
        $display("rounds %0d, wins %0d, mismatches %0d, other errors %0d",
                 round_count, win_total, err_count, other_errors);
        if (err_count == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/answer_judge.sv
// ********************
// answer judge
// sticky per-round verdict from the presses
// against the shown target
// ********************

`timescale 1ns/1ps
`default_nettype none

module answer_judge (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        round_start,
    input  wire                        press,
    input  wire mini_game_pkg::led_index_t press_index,
    input  wire                        single,
    input  wire mini_game_pkg::led_index_t target,
    output mini_game_pkg::verdict_t    verdict
);
    import mini_game_pkg::*;

    logic press_ok;

    // single switch, right index, not already wrong
    assign press_ok = single && (press_index == target) && (verdict != wrong);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            verdict <= none;
        end else if (round_start) begin
            // fresh round, nothing pressed yet
            verdict <= none;
        end else if (press) begin
            if (press_ok) begin
                verdict <= correct;
            end else begin
                // wrong index, several switches or 10..14
                verdict <= wrong;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/game_fsm.sv
// ********************
// game fsm
// idle / led_on / led_off sequencing, enable latch,
// target register, score and done pulse
// ********************

`timescale 1ns/1ps
`default_nettype none

module game_fsm #(
    parameter int unsigned WIN_COUNT = 3
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        enable_game,
    input  wire mini_game_pkg::led_index_t random_out,
    input  wire mini_game_pkg::verdict_t   verdict,
    input  wire                        window_done,
    output logic                       timer_clear,
    output logic                       on_phase,
    output logic                       round_start,
    output mini_game_pkg::led_index_t  random_led,
    output mini_game_pkg::score_t      count,
    output logic                       game_done,
    output logic                       game_led_off
);
    import mini_game_pkg::*;

    game_state_t state;
    game_state_t state_next;
    logic        en_latch;
    score_t      count_inc;
    logic        round_win;

    assign count_inc = count + score_t'(1);

    // this round reaches the win count
    assign round_win = (verdict == correct) && (count_inc == score_t'(WIN_COUNT));

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (en_latch && !game_done) begin
                    state_next = led_on;
                end
            end
            led_on: begin
                if (window_done) begin
                    state_next = round_win ? idle : led_off;
                end
            end
            led_off: begin
                if (window_done) begin
                    state_next = led_on;
                end
            end
            default: state_next = idle;
        endcase
    end

    // timer restarts on every state change
    assign timer_clear = (state_next != state);
    assign on_phase    = (state == led_on);
    // verdict cleared on every entry to led_on
    assign round_start = (state_next == led_on) && (state != led_on);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= idle;
            en_latch     <= 1'b0;
            random_led   <= '0;
            count        <= '0;
            game_done    <= 1'b0;
            game_led_off <= 1'b1;
        end else begin
            state     <= state_next;
            // done is a single-cycle pulse
            game_done <= 1'b0;

            if (enable_game && !game_done) begin
                en_latch <= 1'b1;
            end

            case (state)
                idle: begin
                    if (state_next == led_on) begin
                        // new game
                        random_led   <= random_out;
                        game_led_off <= 1'b0;
                        count        <= '0;
                    end
                end
                led_on: begin
                    if (window_done) begin
                        game_led_off <= 1'b1;
                        if (round_win) begin
                            // win, back to idle and wait for enable again
                            count     <= '0;
                            game_done <= 1'b1;
                            en_latch  <= 1'b0;
                        end else if (verdict == correct) begin
                            count <= count_inc;
                        end else begin
                            // wrong or silent round
                            count <= '0;
                        end
                    end
                end
                led_off: begin
                    if (window_done) begin
                        // next target
                        random_led   <= random_out;
                        game_led_off <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mini_game.sv
// ********************
// mini game top
// reaction game, shows a random target and scores
// the switch presses against it
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mini_game_settings.svh"

module mini_game #(
    parameter int unsigned CLOCK_FREQ   = `MG_CLOCK_FREQ,
    parameter int unsigned ON_TIME_SEC  = `MG_ON_TIME_SEC,
    parameter int unsigned OFF_TIME_SEC = `MG_OFF_TIME_SEC,
    parameter int unsigned WIN_COUNT    = `MG_WIN_COUNT
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          enable_game,
    input  wire mini_game_pkg::switch_word_t spdt_switches,
    input  wire mini_game_pkg::led_index_t   random_out,
    output mini_game_pkg::led_index_t    random_led,
    output mini_game_pkg::score_t        count,
    output logic                         game_done,
    output logic                         game_led_off
);
    import mini_game_pkg::*;

    // window lengths in cycles
    localparam int unsigned ON_CYCLES  = CLOCK_FREQ * ON_TIME_SEC;
    localparam int unsigned OFF_CYCLES = CLOCK_FREQ * OFF_TIME_SEC;

    logic       press;
    led_index_t press_index;
    logic       single;
    verdict_t   verdict;
    logic       timer_clear;
    logic       on_phase;
    logic       window_done;
    logic       round_start;

    switch_press_detect u_press (
        .clk           (clk),
        .reset         (reset),
        .spdt_switches (spdt_switches),
        .press         (press),
        .press_index   (press_index),
        .single        (single)
    );

    phase_timer #(
        .ON_CYCLES  (ON_CYCLES),
        .OFF_CYCLES (OFF_CYCLES)
    ) u_timer (
        .clk         (clk),
        .reset       (reset),
        .timer_clear (timer_clear),
        .on_phase    (on_phase),
        .window_done (window_done)
    );

    // judged against the registered target
    answer_judge u_judge (
        .clk         (clk),
        .reset       (reset),
        .round_start (round_start),
        .press       (press),
        .press_index (press_index),
        .single      (single),
        .target      (random_led),
        .verdict     (verdict)
    );

    game_fsm #(
        .WIN_COUNT (WIN_COUNT)
    ) u_fsm (
        .clk          (clk),
        .reset        (reset),
        .enable_game  (enable_game),
        .random_out   (random_out),
        .verdict      (verdict),
        .window_done  (window_done),
        .timer_clear  (timer_clear),
        .on_phase     (on_phase),
        .round_start  (round_start),
        .random_led   (random_led),
        .count        (count),
        .game_done    (game_done),
        .game_led_off (game_led_off)
    );

endmodule

`default_nettype wire

//--- hw/mini_game_pkg.sv
// ********************
// mini game package
// shared types for the reaction game
// ********************

`default_nettype none

`include "mini_game_settings.svh"

package mini_game_pkg;

    // target or switch index, MG_NO_INDEX when invalid
    typedef logic [`MG_INDEX_W-1:0] led_index_t;

    // raw switch vector
    typedef logic [`MG_SWITCH_W-1:0] switch_word_t;

    // correct rounds in a row
    typedef logic [`MG_SCORE_W-1:0] score_t;

    // game FSM states
    typedef enum logic [1:0] {
        idle    = 2'd0,
        led_on  = 2'd1,
        led_off = 2'd2
    } game_state_t;

    // per-round verdict, wrong is sticky
    typedef enum logic [1:0] {
        none    = 2'd0,
        correct = 2'd1,
        wrong   = 2'd2
    } verdict_t;

endpackage

`default_nettype wire

//--- hw/mini_game_settings.svh
// ********************
// mini game settings
// default timing, win count and field widths
// for the reaction game
// ********************

`ifndef MINI_GAME_SETTINGS_SVH
`define MINI_GAME_SETTINGS_SVH

// clock cycles per second
`define MG_CLOCK_FREQ 12_500_000
// target shown, then pause, in seconds
`define MG_ON_TIME_SEC 2
`define MG_OFF_TIME_SEC 1
// correct rounds in a row for a win
`define MG_WIN_COUNT 3

// only switches 0..9 can be targets
`define MG_NUM_TARGETS 10
// index meaning no valid switch
`define MG_NO_INDEX 15

// field widths
`define MG_TIMER_W 32
`define MG_INDEX_W 4
`define MG_SWITCH_W 15
`define MG_SCORE_W 4

`endif

//--- hw/phase_timer.sv
// ********************
// phase timer
// counts cycles since the last clear and flags the
// end of the on or off window
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mini_game_settings.svh"

module phase_timer #(
    parameter int unsigned ON_CYCLES  = 16,
    parameter int unsigned OFF_CYCLES = 8
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  timer_clear,
    input  wire  on_phase,
    output logic window_done
);

    localparam logic [`MG_TIMER_W-1:0] ON_LIMIT  = `MG_TIMER_W'(ON_CYCLES);
    localparam logic [`MG_TIMER_W-1:0] OFF_LIMIT = `MG_TIMER_W'(OFF_CYCLES);

    logic [`MG_TIMER_W-1:0] cycle_cnt;
    logic [`MG_TIMER_W-1:0] limit;

    // limit follows the current phase
    assign limit = on_phase ? ON_LIMIT : OFF_LIMIT;

    // window spans limit+1 cycles, count 0..limit
    assign window_done = (cycle_cnt >= limit);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
        end else if (timer_clear) begin
            cycle_cnt <= '0;
        end else if (!window_done) begin
            // hold at the limit, e.g. while idle
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/switch_press_detect.sv
// ********************
// switch press detect
// registers the switch word, flags a press on a
// change to a nonzero word, and encodes the index
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mini_game_settings.svh"

module switch_press_detect (
    input  wire                          clk,
    input  wire                          reset,
    input  wire mini_game_pkg::switch_word_t spdt_switches,
    output logic                         press,
    output mini_game_pkg::led_index_t    press_index,
    output logic                         single
);
    import mini_game_pkg::*;

    // current and previous registered switch words
    switch_word_t sw_q;
    switch_word_t sw_prev;
    led_index_t   index_enc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sw_q    <= '0;
            sw_prev <= '0;
        end else begin
            sw_q    <= spdt_switches;
            sw_prev <= sw_q;
        end
    end

    // press on any change to a nonzero word
    assign press = (sw_q != '0) && (sw_q != sw_prev);

    // exactly one of all fifteen switches up
    assign single = $onehot(sw_q);

    // highest set bit among target switches only
    always_comb begin
        index_enc = led_index_t'(`MG_NO_INDEX);
        for (int i = 0; i < `MG_NUM_TARGETS; i++) begin
            if (sw_q[i]) begin
                index_enc = led_index_t'(i);
            end
        end
    end

    assign press_index = index_enc;

endmodule

`default_nettype wire

//--- mini_game.f
+incdir+hw
hw/mini_game_pkg.sv
hw/switch_press_detect.sv
hw/phase_timer.sv
hw/answer_judge.sv
hw/game_fsm.sv
hw/mini_game.sv
dv/mini_game_assert.sv
dv/mini_game_checker.sv
dv/tb_mini_game.sv
